// File: logic/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;  // 256
    localparam int NUM_SETS       = 128;
    localparam int INDEX_W        = $clog2(NUM_SETS);         // 7
    localparam int OFFSET_W       = $clog2(LINE_W / 8);       // 5, byte offset
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_WAYS       = 2;

    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [LINE_W-1:0]                 line_t;  // word 0 in the low bits
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        ASK_A,
        ASK_B,
        REFILL_DONE
    } miss_state_t;

    // index is the read address, tag and word belong to the pair in compare
    typedef struct packed {
        index_t    index_a;
        index_t    index_b;
        tag_t      tag_a;
        tag_t      tag_b;
        word_sel_t word_a;
        word_sel_t word_b;
    } lookup_t;

    typedef struct packed {
        index_t index;
        tag_t   tag;
        line_t  data;
    } refill_t;

    typedef struct packed {
        logic  hit_a;
        logic  hit_b;
        word_t word_a;
        word_t word_b;
    } way_result_t;

    typedef struct packed {
        addr_t pc;
        word_t inst_a;
        word_t inst_b;
        logic  valid;
    } fetch_pair_t;

endpackage

// File: logic/miss_fsm.sv
`timescale 1ns/1ns

module miss_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fetch_en_i,
    input  icache_pkg::addr_t               pc_i,
    input  logic                            flush_i,
    input  logic                            ret_valid_i,
    input  icache_pkg::line_t               ret_data_i,
    input  logic                            hit_a_i,
    input  logic                            hit_b_i,
    input  logic                            victim_way_i,
    output logic                            stall_o,
    output logic                            rd_req_o,
    output icache_pkg::addr_t               rd_addr_o,
    output icache_pkg::lookup_t             lookup_o,
    output icache_pkg::refill_t             refill_o,
    output logic [icache_pkg::NUM_WAYS-1:0] refill_we_o,
    output icache_pkg::index_t              lru_index_o,
    output logic                            pending_o,
    output icache_pkg::addr_t               pc_o,
    output logic                            flush_mask_o
);
    import icache_pkg::*;

    miss_state_t state, next_state;
    addr_t pc_q, pc_b_q;  // held pair
    addr_t pc_b_in;
    addr_t miss_addr;
    logic  pending;       // pair waiting in compare stage
    logic  hit_b_q;
    logic  flush_q;
    logic  drop_one;
    logic  accept;
    logic  miss_seen;
    logic  asking;
    logic  ret_ok;
    logic  same_line;

    function automatic index_t index_of(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t tag_of(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    assign pc_b_in      = pc_i + ADDR_W'(4);
    assign flush_mask_o = flush_i | flush_q;
    assign asking       = (state == ASK_A) || (state == ASK_B);
    assign same_line    = pc_q[ADDR_W-1:OFFSET_W] == pc_b_q[ADDR_W-1:OFFSET_W];
    assign ret_ok       = ret_valid_i && !drop_one && !flush_i;  // orphaned return is eaten

    assign miss_seen = (state == IDLE) && pending && !flush_mask_o && !(hit_a_i && hit_b_i);
    assign stall_o   = (state != IDLE) || miss_seen || flush_i;
    assign accept    = fetch_en_i && !stall_o;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss_seen) begin
                    next_state = hit_a_i ? ASK_B : ASK_A;
                end
            end
            ASK_A: begin
                if (ret_ok) begin
                    next_state = (same_line || hit_b_q) ? REFILL_DONE : ASK_B;
                end
            end
            ASK_B: begin
                if (ret_ok) begin
                    next_state = REFILL_DONE;
                end
            end
            REFILL_DONE: next_state = IDLE;
            default:     next_state = IDLE;
        endcase
        if (flush_mask_o) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            pending  <= 1'b0;
            hit_b_q  <= 1'b0;
            flush_q  <= 1'b0;
        end else begin
            state   <= next_state;
            pending <= accept || (state == REFILL_DONE && !flush_i);  // replay held pair
            flush_q <= flush_i;
            if (state == IDLE) begin
                hit_b_q <= hit_b_i;
            end
        end
    end

    // flush with a request in flight leaves one return to throw away
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_one <= 1'b0;
        end else if (flush_i && ret_valid_i) begin
            drop_one <= 1'b0;
        end else if (flush_i && asking) begin
            drop_one <= 1'b1;
        end else if (ret_valid_i) begin
            drop_one <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q   <= pc_i;
            pc_b_q <= pc_b_in;
        end
    end

    always_comb begin
        if (state == IDLE) begin
            lookup_o.index_a = index_of(pc_i);
            lookup_o.index_b = index_of(pc_b_in);
        end else begin
            lookup_o.index_a = index_of(pc_q);
            lookup_o.index_b = index_of(pc_b_q);
        end
        lookup_o.tag_a  = tag_of(pc_q);
        lookup_o.tag_b  = tag_of(pc_b_q);
        lookup_o.word_a = pc_q[OFFSET_W-1:2];
        lookup_o.word_b = pc_b_q[OFFSET_W-1:2];
    end

    assign miss_addr = (state == ASK_B) ? pc_b_q : pc_q;
    assign rd_addr_o = {miss_addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};  // line aligned
    assign rd_req_o  = asking && !flush_i;

    assign refill_o.index = index_of(miss_addr);
    assign refill_o.tag   = tag_of(miss_addr);
    assign refill_o.data  = ret_data_i;
    assign lru_index_o    = refill_o.index;
    assign refill_we_o    = (asking && ret_ok) ? (NUM_WAYS'(1) << victim_way_i) : '0;

    assign pending_o = pending;
    assign pc_o      = pc_q;

    a_no_req_idle: assert property (@(posedge clk) disable iff (reset)
        state == IDLE |-> !rd_req_o);

    a_one_way_written: assert property (@(posedge clk) disable iff (reset)
        $onehot0(refill_we_o));

    // memory side sees a stable request until it answers or a flush drops it
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        rd_req_o && !ret_valid_i && !flush_i |=> flush_i || (rd_req_o && $stable(rd_addr_o)));

endmodule

// File: logic/icache_way.sv
`timescale 1ns/1ns

module icache_way (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::lookup_t     lookup_i,
    input  icache_pkg::refill_t     refill_i,
    input  logic                    we_i,
    output icache_pkg::way_result_t result_o
);
    import icache_pkg::*;

    line_t               data_mem [NUM_SETS];
    tag_t                tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0] valid;

    line_t  line_a_q;
    line_t  line_b_q;
    tag_t   tag_a_q;
    tag_t   tag_b_q;
    logic   valid_a_q;
    logic   valid_b_q;
    index_t index_a_q;  // set now in compare on port a

    // refill port, whole line at once
    always_ff @(posedge clk) begin
        if (we_i) begin
            data_mem[refill_i.index] <= refill_i.data;
            tag_mem[refill_i.index]  <= refill_i.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (we_i) begin
            valid[refill_i.index] <= 1'b1;
        end
    end

    // two registered read ports
    always_ff @(posedge clk) begin
        line_a_q  <= data_mem[lookup_i.index_a];
        line_b_q  <= data_mem[lookup_i.index_b];
        tag_a_q   <= tag_mem[lookup_i.index_a];
        tag_b_q   <= tag_mem[lookup_i.index_b];
        index_a_q <= lookup_i.index_a;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_a_q <= 1'b0;
            valid_b_q <= 1'b0;
        end else begin
            valid_a_q <= valid[lookup_i.index_a];
            valid_b_q <= valid[lookup_i.index_b];
        end
    end

    // compare stage
    assign result_o.hit_a  = valid_a_q && (tag_a_q == lookup_i.tag_a);
    assign result_o.hit_b  = valid_b_q && (tag_b_q == lookup_i.tag_b);
    assign result_o.word_a = line_a_q[WORD_W*lookup_i.word_a +: WORD_W];
    assign result_o.word_b = line_b_q[WORD_W*lookup_i.word_b +: WORD_W];

    a_hit_needs_valid: assert property (@(posedge clk) disable iff (reset)
        result_o.hit_a |-> valid[index_a_q]);

endmodule

// File: logic/lru_table.sv
`timescale 1ns/1ns

module lru_table (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            hit_a_i,
    input  logic                            hit_b_i,
    input  logic                            hit_way_a_i,
    input  logic                            hit_way_b_i,
    input  icache_pkg::index_t              index_a_i,
    input  icache_pkg::index_t              index_b_i,
    input  logic [icache_pkg::NUM_WAYS-1:0] refill_we_i,
    input  icache_pkg::index_t              refill_index_i,
    output logic                            victim_way_o
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] victim;  // names the way to replace next

    always_ff @(posedge clk) begin
        if (reset) begin
            victim <= '0;
        end else begin
            if (hit_a_i) begin
                victim[index_a_i] <= ~hit_way_a_i;
            end
            if (hit_b_i) begin
                victim[index_b_i] <= ~hit_way_b_i;
            end
            // refill and hits never share a cycle
            if (|refill_we_i) begin
                victim[refill_index_i] <= ~refill_we_i[1];
            end
        end
    end

    assign victim_way_o = victim[refill_index_i];

endmodule

// File: logic/fetch_select.sv
`timescale 1ns/1ns

module fetch_select (
    input  icache_pkg::way_result_t results_i [icache_pkg::NUM_WAYS],
    input  logic                    pending_i,
    input  icache_pkg::addr_t       pc_i,
    input  logic                    flush_mask_i,
    output logic                    hit_a_o,
    output logic                    hit_b_o,
    output logic                    hit_way_a_o,
    output logic                    hit_way_b_o,
    output icache_pkg::fetch_pair_t fetch_o
);
    import icache_pkg::*;

    logic  any_a;
    logic  any_b;
    word_t word_a;
    word_t word_b;

    always_comb begin
        any_a       = 1'b0;
        any_b       = 1'b0;
        hit_way_a_o = 1'b0;
        hit_way_b_o = 1'b0;
        word_a      = '0;
        word_b      = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (results_i[w].hit_a) begin
                any_a       = 1'b1;
                hit_way_a_o = w[0];
                word_a      = results_i[w].word_a;
            end
            if (results_i[w].hit_b) begin
                any_b       = 1'b1;
                hit_way_b_o = w[0];
                word_b      = results_i[w].word_b;
            end
        end
    end

    assign hit_a_o = pending_i && any_a;  // only a real compare counts
    assign hit_b_o = pending_i && any_b;

    assign fetch_o.pc     = pc_i;
    assign fetch_o.inst_a = word_a;
    assign fetch_o.inst_b = word_b;
    assign fetch_o.valid  = hit_a_o && hit_b_o && !flush_mask_i;

    // a line lives in one way only
    always_comb begin
        if (pending_i) begin
            a_single_hit: assert final (!(results_i[0].hit_a && results_i[1].hit_a) &&
                                        !(results_i[0].hit_b && results_i[1].hit_b));
        end
    end

endmodule

// File: logic/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_en_i,
    input  icache_pkg::addr_t       pc_i,
    input  logic                    flush_i,
    input  logic                    ret_valid_i,
    input  icache_pkg::line_t       ret_data_i,
    output logic                    stall_o,
    output icache_pkg::fetch_pair_t fetch_o,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o
);
    import icache_pkg::*;

    lookup_t             lookup;
    refill_t             refill;
    logic [NUM_WAYS-1:0] refill_we;
    way_result_t         results [NUM_WAYS];

    logic   hit_a;
    logic   hit_b;
    logic   hit_way_a;
    logic   hit_way_b;
    logic   victim_way;
    logic   pending;
    logic   flush_mask;
    index_t lru_index;
    addr_t  held_pc;
    addr_t  held_pc_b;

    assign held_pc_b = held_pc + ADDR_W'(4);  // compare-stage pair for lru

    miss_fsm u_miss_fsm (
        .clk          (clk),
        .reset        (reset),
        .fetch_en_i   (fetch_en_i),
        .pc_i         (pc_i),
        .flush_i      (flush_i),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .hit_a_i      (hit_a),
        .hit_b_i      (hit_b),
        .victim_way_i (victim_way),
        .stall_o      (stall_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .lookup_o     (lookup),
        .refill_o     (refill),
        .refill_we_o  (refill_we),
        .lru_index_o  (lru_index),
        .pending_o    (pending),
        .pc_o         (held_pc),
        .flush_mask_o (flush_mask)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk      (clk),
            .reset    (reset),
            .lookup_i (lookup),
            .refill_i (refill),
            .we_i     (refill_we[w]),
            .result_o (results[w])
        );
    end

    lru_table u_lru_table (
        .clk            (clk),
        .reset          (reset),
        .hit_a_i        (hit_a),
        .hit_b_i        (hit_b),
        .hit_way_a_i    (hit_way_a),
        .hit_way_b_i    (hit_way_b),
        .index_a_i      (held_pc[OFFSET_W +: INDEX_W]),
        .index_b_i      (held_pc_b[OFFSET_W +: INDEX_W]),
        .refill_we_i    (refill_we),
        .refill_index_i (lru_index),
        .victim_way_o   (victim_way)
    );

    fetch_select u_fetch_select (
        .results_i    (results),
        .pending_i    (pending),
        .pc_i         (held_pc),
        .flush_mask_i (flush_mask),
        .hit_a_o      (hit_a),
        .hit_b_o      (hit_b),
        .hit_way_a_o  (hit_way_a),
        .hit_way_b_o  (hit_way_b),
        .fetch_o      (fetch_o)
    );

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;
    import icache_pkg::*;

    localparam int    ACCEPT_LIMIT = 50;
    localparam int    RESULT_LIMIT = 300;
    localparam word_t DATA_KEY     = 32'h5a5a0000;

    logic        clk         = 1'b0;
    logic        reset       = 1'b1;
    logic        fetch_en_i  = 1'b0;
    addr_t       pc_i        = '0;
    logic        flush_i     = 1'b0;
    logic        ret_valid_i = 1'b0;
    line_t       ret_data_i  = '0;
    logic        stall_o;
    fetch_pair_t fetch_o;
    logic        rd_req_o;
    addr_t       rd_addr_o;

    string t_name[$];  // stimulus table
    addr_t t_pc[$];
    logic  t_flush[$];
    int    t_reqs[$];

    logic        mem_busy  = 1'b0;
    addr_t       mem_addr  = '0;
    int          mem_wait  = 0;
    int          req_count = 0;
    addr_t       req_log[$];  // address of every request the memory took, in order
    logic [31:0] rng_state = 32'd31;

    int   test_errors  = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    logic timed_out    = 1'b0;

    icache_top UUT (
        .clk         (clk),
        .reset       (reset),
        .fetch_en_i  (fetch_en_i),
        .pc_i        (pc_i),
        .flush_i     (flush_i),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .stall_o     (stall_o),
        .fetch_o     (fetch_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic line_t mem_line(input addr_t line_addr);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_W +: WORD_W] = (line_addr + addr_t'(4 * w)) ^ DATA_KEY;
        end
        return l;
    endfunction

    // memory answers 1 to 8 cycles after taking a request, even if it was dropped since
    always @(posedge clk) begin
        ret_valid_i <= 1'b0;
        if (reset) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                ret_valid_i <= 1'b1;
                ret_data_i  <= mem_line(mem_addr);
                mem_busy    <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else if (rd_req_o && !ret_valid_i) begin  // skip the edge that consumes a return
            rng_state = xorshift32(rng_state);
            req_log.push_back(rd_addr_o);
            mem_busy  <= 1'b1;
            mem_addr  <= rd_addr_o;
            mem_wait  <= int'(rng_state[2:0]);
            req_count <= req_count + 1;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic add_entry(input string name, input addr_t pc, input logic flush,
                             input int reqs);
        t_name.push_back(name);
        t_pc.push_back(pc);
        t_flush.push_back(flush);
        t_reqs.push_back(reqs);
    endtask

    task automatic check_quiet_outputs();
        check_value("reset", "stall_o", 0, stall_o);
        check_value("reset", "rd_req_o", 0, rd_req_o);
        check_value("reset", "valid", 0, fetch_o.valid);
    endtask

    task automatic wait_result(input int i, input int start_reqs);
        int    cycles;
        addr_t pc;
        pc     = t_pc[i];
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!fetch_o.valid && cycles < RESULT_LIMIT);
        if (!fetch_o.valid) begin
            $display("Timeout: %s got no fetch result (rd_req_o=%b stall_o=%b)",
                     t_name[i], rd_req_o, stall_o);
            timed_out = 1'b1;
            return;
        end
        check_value(t_name[i], "pc", pc, fetch_o.pc);
        check_value(t_name[i], "inst_a", pc ^ DATA_KEY, fetch_o.inst_a);
        check_value(t_name[i], "inst_b", (pc + 32'd4) ^ DATA_KEY, fetch_o.inst_b);
        check_value(t_name[i], "stall_o", 0, stall_o);
        check_value(t_name[i], "requests", t_reqs[i], req_count - start_reqs);
        // 32-byte lines, line A asked for before line B
        if (t_reqs[i] > 0 && req_log.size() > start_reqs) begin
            check_value(t_name[i], "rd_addr_a", pc & ~32'h1f, req_log[start_reqs]);
        end
        if (t_reqs[i] > 1 && req_log.size() > start_reqs + 1) begin
            check_value(t_name[i], "rd_addr_b", (pc + 32'd4) & ~32'h1f,
                        req_log[start_reqs + 1]);
        end
        if (t_reqs[i] == 0) begin
            check_value(t_name[i], "latency", 1, cycles);  // hit answers next cycle
        end
    endtask

    task automatic flush_and_watch(input int i, input int start_reqs);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            check_value(t_name[i], "valid", 0, fetch_o.valid);
        end while (!rd_req_o && cycles < ACCEPT_LIMIT);
        if (!rd_req_o) begin
            $display("Timeout: %s never raised a memory request", t_name[i]);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        check_value(t_name[i], "rd_req_o", 0, rd_req_o);
        check_value(t_name[i], "valid", 0, fetch_o.valid);
        // orphaned return still in flight when the next fetch misses
        check_value(t_name[i], "requests", t_reqs[i], req_count - start_reqs);
    endtask

    task automatic run_entry(input int i);
        int start_reqs;
        int cycles;
        start_reqs = req_count;
        cycles     = 0;
        @(posedge clk);
        fetch_en_i <= 1'b1;
        pc_i       <= t_pc[i];
        do begin
            @(negedge clk);
            cycles++;
        end while (stall_o && cycles < ACCEPT_LIMIT);
        if (stall_o) begin
            $display("Timeout: %s was never accepted, stall_o stayed high", t_name[i]);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);  // acceptance edge
        fetch_en_i <= 1'b0;
        if (t_flush[i]) begin
            flush_and_watch(i, start_reqs);
        end else begin
            wait_result(i, start_reqs);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0 && !timed_out) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed, %0d errors", name, test_errors);
        end
    endtask

    initial begin
        int cycle;
        add_entry("cold_mid_line", 32'h0000_1208, 1'b0, 1);
        add_entry("repeat_hit", 32'h0000_1208, 1'b0, 0);
        add_entry("line_end", 32'h0000_203c, 1'b0, 2);
        add_entry("lru_x", 32'h0000_4400, 1'b0, 1);
        add_entry("lru_y", 32'h0000_5400, 1'b0, 1);
        add_entry("lru_x_again", 32'h0000_4400, 1'b0, 0);
        add_entry("lru_z", 32'h0000_6400, 1'b0, 1);  // set 0x20, y is victim
        add_entry("lru_x_kept", 32'h0000_4400, 1'b0, 0);
        add_entry("lru_y_evicted", 32'h0000_5400, 1'b0, 1);
        add_entry("flush_pending", 32'h0000_8800, 1'b1, 1);
        add_entry("after_flush", 32'h0000_9804, 1'b0, 1);

        for (cycle = 0; cycle < 8; cycle++) begin
            @(posedge clk);
            if (cycle == 7) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_quiet_outputs();
        end
        @(negedge clk);
        check_quiet_outputs();
        report_test("reset");

        foreach (t_name[i]) begin
            if (!timed_out) begin
                test_errors = 0;
                run_entry(i);
                report_test(t_name[i]);
            end
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
logic/icache_pkg.sv
logic/miss_fsm.sv
logic/icache_way.sv
logic/lru_table.sv
logic/fetch_select.sv
logic/icache_top.sv
verification/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - logic/icache_pkg.sv
      - logic/miss_fsm.sv
      - logic/icache_way.sv
      - logic/lru_table.sv
      - logic/fetch_select.sv
      - logic/icache_top.sv
  - target: test
    files:
      - verification/icache_tb.sv
